// ==== group_pkg.sv ====
package group_pkg;

    // ##############################
    // widths
    // ##############################

    // a group always has four lanes since the adder tree is built for four
    localparam int GROUP_NB  = 4;
    localparam int PIX_WIDTH = 8;
    localparam int W_WIDTH   = 8;
    localparam int NUM_WIDTH = 16;
    localparam int OUT_WIDTH = 8;
    localparam int TAP_AW    = 4;

    // ##############################
    // scalar types
    // ##############################

    typedef logic signed [PIX_WIDTH-1:0] pix_t;
    typedef logic signed [W_WIDTH-1:0]   weight_t;
    typedef logic signed [NUM_WIDTH-1:0] num_t;
    typedef logic [TAP_AW-1:0]           tap_t;

    // ##############################
    // grouped types
    // ##############################

    // lane 0 sits in the low bits of every group word
    typedef struct packed {
        pix_t [GROUP_NB-1:0] lane;
    } pix_group_t;

    typedef struct packed {
        weight_t [GROUP_NB-1:0] lane;
    } weight_group_t;

    typedef struct packed {
        num_t [GROUP_NB-1:0] lane;
    } num_group_t;

    // one weight write, addressed by lane and tap
    typedef struct packed {
        logic [$clog2(GROUP_NB)-1:0] lane;
        tap_t                        tap;
        weight_t                     data;
    } weight_wr_t;

    typedef enum logic {ACT_NONE, ACT_RELU} act_mode_e;

    typedef enum logic {MAC_IDLE, MAC_ACCUM} mac_state_e;

endpackage

// ==== kernel_store.sv ====
module kernel_store #(
    parameter int unsigned TAP_NB = 9
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     w_wr,
    input  group_pkg::weight_wr_t    w_cmd,
    input  logic                     rd_en,
    input  group_pkg::tap_t          rd_tap,
    output group_pkg::weight_group_t weights
);

    // one row per tap, each row holds the weights of all four lanes
    group_pkg::weight_group_t mem [TAP_NB];

    // ##############################
    // parameter check
    // ##############################

    if (TAP_NB < 1 || TAP_NB > 2 ** group_pkg::TAP_AW) begin : g_bad_tap_nb
        $error("kernel_store TAP_NB must lie between 1 and %0d", 2 ** group_pkg::TAP_AW);
    end

    // ##############################
    // write port
    // ##############################

    // a write touches a single lane entry and leaves the other three alone
    always_ff @(posedge clk) begin
        if (w_wr && (w_cmd.tap < TAP_NB)) begin
            mem[w_cmd.tap].lane[w_cmd.lane] <= w_cmd.data;
        end
    end

    // ##############################
    // read port
    // ##############################

    // the whole row is registered so the MAC sees all lanes one cycle after rd_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights <= '0;
        end else if (rd_en) begin
            weights <= mem[rd_tap];
        end
    end

endmodule

// ==== group_mac.sv ====
module group_mac #(
    parameter int unsigned TAP_NB = 9
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pix_valid,
    input  logic                     pix_first,
    input  logic                     pix_last,
    input  group_pkg::pix_group_t    pix,
    input  group_pkg::weight_group_t weights,
    output logic                     rd_en,
    output group_pkg::tap_t          rd_tap,
    output logic                     mac_valid,
    output group_pkg::num_group_t    lanes
);

    localparam group_pkg::tap_t LAST_TAP = group_pkg::tap_t'(TAP_NB - 1);

    group_pkg::mac_state_e state;
    group_pkg::tap_t       tap_cnt;
    logic                  accept;

    // stage 1, pixels wait here for the weights coming back from the store
    logic                  pix_vld_d;
    logic                  first_d;
    logic                  last_d;
    group_pkg::pix_group_t pix_d;

    // stage 2 holds the registered products
    logic                  prod_vld;
    logic                  prod_first;
    logic                  prod_last;
    group_pkg::num_group_t prod;

    // ##############################
    // tap sequencing
    // ##############################

    // a strobe outside a window is only taken when it opens one
    assign accept = pix_valid && (pix_first || state == group_pkg::MAC_ACCUM);
    assign rd_en  = accept;
    assign rd_tap = pix_first ? '0 : tap_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= group_pkg::MAC_IDLE;
            tap_cnt <= '0;
        end else if (accept) begin
            if (pix_last) begin
                // the tail of the window is still in the pipeline
                state   <= group_pkg::MAC_IDLE;
                tap_cnt <= '0;
            end else begin
                state   <= group_pkg::MAC_ACCUM;
                tap_cnt <= (rd_tap == LAST_TAP) ? '0 : rd_tap + 1'b1;
            end
        end
    end

    // ##############################
    // marker pipeline
    // ##############################

    // first and last markers travel in step with the data they belong to
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_vld_d <= 1'b0;
            first_d   <= 1'b0;
            last_d    <= 1'b0;
            prod_vld  <= 1'b0;
            prod_first <= 1'b0;
            prod_last <= 1'b0;
            mac_valid <= 1'b0;
        end else begin
            pix_vld_d  <= accept;
            first_d    <= accept && pix_first;
            last_d     <= accept && pix_last;
            prod_vld   <= pix_vld_d;
            prod_first <= first_d;
            prod_last  <= last_d;
            mac_valid  <= prod_vld && prod_last;
        end
    end

    // ##############################
    // multiply and accumulate
    // ##############################

    always_ff @(posedge clk) begin
        pix_d <= pix;
        for (int i = 0; i < group_pkg::GROUP_NB; i++) begin
            // an 8 by 8 signed product always fits in the lane width
            prod.lane[i] <= group_pkg::num_t'(pix_d.lane[i]) *
                            group_pkg::num_t'(weights.lane[i]);
        end
    end

    // the first tap of a window restarts each lane from its product
    always_ff @(posedge clk) begin
        if (prod_vld) begin
            for (int i = 0; i < group_pkg::GROUP_NB; i++) begin
                lanes.lane[i] <= prod_first ? prod.lane[i] : lanes.lane[i] + prod.lane[i];
            end
        end
    end

endmodule

// ==== group_add.sv ====
module group_add (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mac_valid,
    input  group_pkg::num_group_t lanes,
    output logic                  sum_valid,
    output group_pkg::num_t       sum
);

    // valid bits of stages one to four, sum_valid is the fifth
    logic [3:0] vld_pipe;

    group_pkg::num_group_t lanes_r;
    group_pkg::num_t       pair_3p [2];
    group_pkg::num_t       pair_2p [2];
    group_pkg::num_t       total_1p;

    // two's complement add that wraps at the lane width
    function automatic group_pkg::num_t add_wrap(
        input group_pkg::num_t a,
        input group_pkg::num_t b
    );
        return a + b;
    endfunction

    // ##############################
    // valid pipeline
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe  <= '0;
            sum_valid <= 1'b0;
        end else begin
            {sum_valid, vld_pipe} <= {vld_pipe, mac_valid};
        end
    end

    // ##############################
    // adder tree
    // ##############################

    always_ff @(posedge clk) begin
        // stage 1 registers the lane totals
        lanes_r <= lanes;

        // stage 2 adds neighbouring lanes
        pair_3p[0] <= add_wrap(lanes_r.lane[0], lanes_r.lane[1]);
        pair_3p[1] <= add_wrap(lanes_r.lane[2], lanes_r.lane[3]);

        // stage 3 only balances the path for timing
        pair_2p[0] <= pair_3p[0];
        pair_2p[1] <= pair_3p[1];

        // stage 4 joins the two pair sums
        total_1p <= add_wrap(pair_2p[0], pair_2p[1]);

        // stage 5 is the output register
        sum <= total_1p;
    end

endmodule

// ==== result_scale.sv ====
module result_scale #(
    parameter int unsigned SHIFT = 4
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sum_valid,
    input  group_pkg::num_t                    sum,
    input  group_pkg::act_mode_e               act_mode,
    output logic                               out_valid,
    output logic signed [group_pkg::OUT_WIDTH-1:0] out_data
);

    // limits of the signed output range, held at the sum width
    localparam group_pkg::num_t SAT_HI =
        group_pkg::num_t'(2 ** (group_pkg::OUT_WIDTH - 1) - 1);
    localparam group_pkg::num_t SAT_LO =
        group_pkg::num_t'(-(2 ** (group_pkg::OUT_WIDTH - 1)));

    group_pkg::num_t                        shifted;
    group_pkg::num_t                        activated;
    logic signed [group_pkg::OUT_WIDTH-1:0] clipped;

    // ##############################
    // scale, activate, saturate
    // ##############################

    always_comb begin
        shifted = sum >>> SHIFT;

        activated = shifted;
        if (act_mode == group_pkg::ACT_RELU && shifted < 0) begin
            activated = '0;
        end

        // after clipping only the low bits carry information
        if (activated > SAT_HI) begin
            clipped = SAT_HI[group_pkg::OUT_WIDTH-1:0];
        end else if (activated < SAT_LO) begin
            clipped = SAT_LO[group_pkg::OUT_WIDTH-1:0];
        end else begin
            clipped = activated[group_pkg::OUT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_data <= clipped;
    end

endmodule

// ==== group_top.sv ====
module group_top #(
    parameter int unsigned TAP_NB = 9,
    parameter int unsigned SHIFT  = 4
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   w_wr,
    input  group_pkg::weight_wr_t                  w_cmd,
    input  logic                                   pix_valid,
    input  logic                                   pix_first,
    input  logic                                   pix_last,
    input  group_pkg::pix_group_t                  pix,
    input  group_pkg::act_mode_e                   act_mode,
    output logic                                   out_valid,
    output logic signed [group_pkg::OUT_WIDTH-1:0] out_data
);

    logic                     rd_en;
    group_pkg::tap_t          rd_tap;
    group_pkg::weight_group_t weights;
    logic                     mac_valid;
    group_pkg::num_group_t    lanes;
    logic                     sum_valid;
    group_pkg::num_t          sum;

    // ##############################
    // weight memory and lane MACs
    // ##############################

    kernel_store #(
        .TAP_NB (TAP_NB)
    ) kernel_store_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .w_wr    (w_wr),
        .w_cmd   (w_cmd),
        .rd_en   (rd_en),
        .rd_tap  (rd_tap),
        .weights (weights)
    );

    group_mac #(
        .TAP_NB (TAP_NB)
    ) group_mac_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_first (pix_first),
        .pix_last  (pix_last),
        .pix       (pix),
        .weights   (weights),
        .rd_en     (rd_en),
        .rd_tap    (rd_tap),
        .mac_valid (mac_valid),
        .lanes     (lanes)
    );

    // ##############################
    // reduction and output stage
    // ##############################

    group_add group_add_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac_valid (mac_valid),
        .lanes     (lanes),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    // act_mode is a level held over the window, so it feeds the scaler directly
    result_scale #(
        .SHIFT (SHIFT)
    ) result_scale_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_valid (sum_valid),
        .sum       (sum),
        .act_mode  (act_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== group_assert.sv ====
module group_assert (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  mac_valid,
    input group_pkg::num_group_t lanes,
    input logic                  sum_valid,
    input group_pkg::num_t       sum
);

    timeunit 1ns;
    timeprecision 1ps;

    // failures seen so far, read by the testbench when the run ends
    int fail_nb = 0;

    function automatic group_pkg::num_t lane_total(input group_pkg::num_group_t g);
        group_pkg::num_t acc;
        acc = '0;
        for (int i = 0; i < group_pkg::GROUP_NB; i++) begin
            acc = acc + g.lane[i];
        end
        return acc;
    endfunction

    // ##############################
    // adder tree properties
    // ##############################

    a_sum_value: assert property (@(posedge clk) disable iff (!rst_n)
        sum_valid |-> sum == $past(lane_total(lanes), 5))
        else begin
            $error("group sum differs from the lanes five cycles earlier");
            fail_nb++;
        end

    a_sum_valid: assert property (@(posedge clk) disable iff (!rst_n)
        sum_valid == $past(mac_valid, 5))
        else begin
            $error("sum_valid is not mac_valid delayed by five cycles");
            fail_nb++;
        end

    a_reset_low: assert property (@(posedge clk) !rst_n |-> !sum_valid)
        else begin
            $error("sum_valid is high during reset");
            fail_nb++;
        end

endmodule

bind group_add group_assert group_assert_i (.*);

// ==== tb_group.sv ====
module tb_group;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAP_NB  = 9;
    localparam int SHIFT   = 4;
    localparam int REC_MAX = 512;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   w_wr;
    group_pkg::weight_wr_t                  w_cmd;
    logic                                   pix_valid;
    logic                                   pix_first;
    logic                                   pix_last;
    group_pkg::pix_group_t                  pix;
    group_pkg::act_mode_e                   act_mode;
    logic                                   out_valid;
    logic signed [group_pkg::OUT_WIDTH-1:0] out_data;

    // records read from the data file, kind letter plus up to seven fields
    byte rec_kind [REC_MAX];
    int  rec_f    [REC_MAX][7];
    int  rec_nb;
    int  win_nb;

    logic signed [group_pkg::OUT_WIDTH-1:0] exp_q [$];

    int          cycle;
    int          cycle_limit;
    logic [31:0] lcg_state;
    logic        gaps_on;

    group_top #(
        .TAP_NB (TAP_NB),
        .SHIFT  (SHIFT)
    ) group_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .w_wr      (w_wr),
        .w_cmd     (w_cmd),
        .pix_valid (pix_valid),
        .pix_first (pix_first),
        .pix_last  (pix_last),
        .pix       (pix),
        .act_mode  (act_mode),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    // ##############################
    // clock and timeout
    // ##############################

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    // ##############################
    // helpers
    // ##############################

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return (s * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_out(
        input logic signed [group_pkg::OUT_WIDTH-1:0] got,
        input logic signed [group_pkg::OUT_WIDTH-1:0] exp
    );
        if (got !== exp) begin
            $display("** Error at %0t: out_data is %0d, expected %0d", $time, got, exp);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_idle(input logic vld);
        if (vld !== 1'b0) begin
            $display("** Error at %0t: out_valid is high with no window pending", $time);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    endtask

    task automatic read_records();
        int    fd;
        string line;
        byte   ch;
        int    n;
        fd = $fopen("group_input.txt", "r");
        if (fd == 0) begin
            $display("could not open group_input.txt");
            $display("STATUS: FAIL");
            $fatal(1);
        end
        rec_nb = 0;
        win_nb = 0;
        while (!$feof(fd) && rec_nb < REC_MAX) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %d %d %d %d %d %d %d", ch,
                            rec_f[rec_nb][0], rec_f[rec_nb][1], rec_f[rec_nb][2],
                            rec_f[rec_nb][3], rec_f[rec_nb][4], rec_f[rec_nb][5],
                            rec_f[rec_nb][6]);
                rec_kind[rec_nb] = ch;
                if (ch == "P" && rec_f[rec_nb][1] != 0) begin
                    win_nb++;
                end
                rec_nb++;
            end
        end
        $fclose(fd);
    endtask

    // ##############################
    // output monitor
    // ##############################

    // sampled on the falling edge where DUT outputs are settled
    always @(negedge clk) begin
        if (out_valid === 1'b1 && exp_q.size() > 0) begin
            check_out(out_data, exp_q.pop_front());
        end else if (exp_q.size() == 0) begin
            check_idle(out_valid);
        end
    end

    // ##############################
    // stimulus
    // ##############################

    task automatic send_pixels(input int r);
        int gap;
        // a new activation mode may only be set once earlier windows have left
        if (rec_f[r][0] != 0 && group_pkg::act_mode_e'(rec_f[r][2]) != act_mode) begin
            while (exp_q.size() != 0) begin
                next_cycle();
            end
        end
        act_mode  = group_pkg::act_mode_e'(rec_f[r][2]);
        pix_valid = 1'b1;
        pix_first = rec_f[r][0] != 0;
        pix_last  = rec_f[r][1] != 0;
        for (int i = 0; i < group_pkg::GROUP_NB; i++) begin
            pix.lane[i] = group_pkg::pix_t'(rec_f[r][3+i]);
        end
        next_cycle();
        pix_valid = 1'b0;
        pix_first = 1'b0;
        pix_last  = 1'b0;
        if (gaps_on && rec_f[r][1] == 0) begin
            lcg_state = lcg_next(lcg_state);
            gap = int'((lcg_state >> 16) % 4);
            repeat (gap) next_cycle();
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        w_wr        = 1'b0;
        w_cmd       = '0;
        pix_valid   = 1'b0;
        pix_first   = 1'b0;
        pix_last    = 1'b0;
        pix         = '0;
        act_mode    = group_pkg::ACT_NONE;
        cycle       = 0;
        cycle_limit = 0;
        lcg_state   = 32'd59363;
        gaps_on     = 1'b0;

        read_records();
        cycle_limit = rec_nb * 4 + 9 * win_nb + 100;

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (4) next_cycle();

        for (int r = 0; r < rec_nb; r++) begin
            case (rec_kind[r])
                "W": begin
                    w_wr       = 1'b1;
                    w_cmd.lane = 2'(rec_f[r][0]);
                    w_cmd.tap  = group_pkg::tap_t'(rec_f[r][1]);
                    w_cmd.data = group_pkg::weight_t'(rec_f[r][2]);
                    next_cycle();
                    w_wr = 1'b0;
                end
                "P": send_pixels(r);
                "E": exp_q.push_back(8'(rec_f[r][0]));
                "G": gaps_on = rec_f[r][0] != 0;
                default: begin
                    $display("unknown record kind in group_input.txt at record %0d", r);
                    $display("STATUS: FAIL");
                    $fatal(1);
                end
            endcase
        end

        while (exp_q.size() != 0) begin
            next_cycle();
        end
        // out_valid must stay quiet once every window has left
        repeat (12) next_cycle();

        // the bound adder tree checker counts its own assertion failures
        if (group_top_i.group_add_i.group_assert_i.fail_nb == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== group_input.txt ====
# W lane tap weight | P first last mode p0 p1 p2 p3 | E expected | G gaps_on
# weights: lane0 = tap+1, lane1 = 2, lane2 = -1, lane3 = 3
W 0 0 1
W 1 0 2
W 2 0 -1
W 3 0 3
W 0 1 2
W 1 1 2
W 2 1 -1
W 3 1 3
W 0 2 3
W 1 2 2
W 2 2 -1
W 3 2 3
W 0 3 4
W 1 3 2
W 2 3 -1
W 3 3 3
W 0 4 5
W 1 4 2
W 2 4 -1
W 3 4 3
W 0 5 6
W 1 5 2
W 2 5 -1
W 3 5 3
W 0 6 7
W 1 6 2
W 2 6 -1
W 3 6 3
W 0 7 8
W 1 7 2
W 2 7 -1
W 3 7 3
W 0 8 9
W 1 8 2
W 2 8 -1
W 3 8 3
P 1 0 0 0 1 2 0
P 0 0 0 1 1 2 1
P 0 0 0 2 1 2 2
P 0 0 0 3 1 2 3
P 0 0 0 4 1 2 4
P 0 0 0 5 1 2 5
P 0 0 0 6 1 2 6
P 0 0 0 7 1 2 7
P 0 1 0 8 1 2 8
E 21
P 1 0 1 -10 0 5 0
P 0 0 1 -10 0 5 0
P 0 0 1 -10 0 5 0
P 0 0 1 -10 0 5 0
P 0 0 1 -10 0 5 0
P 0 0 1 -10 0 5 0
P 0 0 1 -10 0 5 0
P 0 0 1 -10 0 5 0
P 0 1 1 -10 0 5 0
E 0
P 1 0 0 -10 0 5 0
P 0 0 0 -10 0 5 0
P 0 0 0 -10 0 5 0
P 0 0 0 -10 0 5 0
P 0 0 0 -10 0 5 0
P 0 0 0 -10 0 5 0
P 0 0 0 -10 0 5 0
P 0 0 0 -10 0 5 0
P 0 1 0 -10 0 5 0
E -31
P 1 0 0 100 100 100 100
P 0 0 0 100 100 100 100
P 0 0 0 100 100 100 100
P 0 0 0 100 100 100 100
P 0 0 0 100 100 100 100
P 0 0 0 100 100 100 100
P 0 0 0 100 100 100 100
P 0 0 0 100 100 100 100
P 0 1 0 100 100 100 100
E 127
P 1 0 0 -100 -100 -100 -100
P 0 0 0 -100 -100 -100 -100
P 0 0 0 -100 -100 -100 -100
P 0 0 0 -100 -100 -100 -100
P 0 0 0 -100 -100 -100 -100
P 0 0 0 -100 -100 -100 -100
P 0 0 0 -100 -100 -100 -100
P 0 0 0 -100 -100 -100 -100
P 0 1 0 -100 -100 -100 -100
E -128
G 1
P 1 0 0 0 1 2 0
P 0 0 0 1 1 2 1
P 0 0 0 2 1 2 2
P 0 0 0 3 1 2 3
P 0 0 0 4 1 2 4
P 0 0 0 5 1 2 5
P 0 0 0 6 1 2 6
P 0 0 0 7 1 2 7
P 0 1 0 8 1 2 8
E 21

// ==== all.f ====
group_pkg.sv
kernel_store.sv
group_mac.sv
group_add.sv
result_scale.sv
group_top.sv
group_assert.sv
tb_group.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the group testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wall \
    --top-module tb_group \
    -f all.f \
    -o sim_group || exit 1

./obj_dir/sim_group > sim.log 2>&1
cat sim.log

grep -q "^STATUS: PASS$" sim.log && exit 0 || exit 1
